// ==== Bender.yml ====
package:
  name: apb_delay

sources:
  - include_dirs:
      - design
    files:
      - design/apb_delay_pkg.sv
      - design/apb_delayer.sv
      - design/apb_reg_bank.sv
      - design/apb_delay_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/apb_delay_checker.sv
      - tests/tb_apb_delay.sv

// ==== all.f ====
+incdir+design
design/apb_delay_pkg.sv
design/apb_delayer.sv
design/apb_reg_bank.sv
design/apb_delay_top.sv
tests/apb_delay_checker.sv
tests/tb_apb_delay.sv

// ==== design/apb_delay_defs.svh ====
`ifndef APB_DELAY_DEFS_SVH
`define APB_DELAY_DEFS_SVH

// apb bus widths
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// fixed-point ratio, fraction bits and default value
// 2.5 in q.10 format
`define APB_DELAY_FRAC 10
`define APB_DELAY_RATIO 2560

// 1 scales the wait states, 0 turns the delayer into plain wires
`define APB_DELAY_ON 1

// register bank depth in 32-bit words
`define REG_BANK_WORDS 16

`endif

// ==== design/apb_delay_pkg.sv ====
`include "apb_delay_defs.svh"

package apb_delay_pkg;

    // plain vector types for the bus fields
    typedef logic [`APB_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0]   data_t;
    typedef logic [`APB_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [2:0]                   prot_t;

    // wait states of the register bank, 0 to 7
    typedef logic [2:0] wait_t;

    // requester to completer
    typedef struct packed {
        addr_t paddr;
        logic  psel;
        logic  penable;
        prot_t pprot;
        logic  pwrite;
        data_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    // completer to requester
    typedef struct packed {
        logic  pready;
        data_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    // delayer fsm
    typedef enum logic [1:0] {
        idle,
        active,
        delay
    } delay_state_t;

endpackage

// ==== design/apb_delay_top.sv ====
`include "apb_delay_defs.svh"

module apb_delay_top
    import apb_delay_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  prot_t pprot,
    input  logic  pwrite,
    input  data_t pwdata,
    input  strb_t pstrb,
    output logic  pready,
    output data_t prdata,
    output logic  pslverr
);

    apb_req_t up_req;
    apb_rsp_t up_rsp;
    apb_req_t dn_req;
    apb_rsp_t dn_rsp;

    // upstream pins into the request struct
    assign up_req.paddr   = paddr;
    assign up_req.psel    = psel;
    assign up_req.penable = penable;
    assign up_req.pprot   = pprot;
    assign up_req.pwrite  = pwrite;
    assign up_req.pwdata  = pwdata;
    assign up_req.pstrb   = pstrb;

    assign pready  = up_rsp.pready;
    assign prdata  = up_rsp.prdata;
    assign pslverr = up_rsp.pslverr;

    apb_delayer #(
        .ratio (64'(`APB_DELAY_RATIO))
    ) apb_delayer_inst (
        .clock  (clock),
        .reset  (reset),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .dn_req (dn_req),
        .dn_rsp (dn_rsp)
    );

    apb_reg_bank apb_reg_bank_inst (
        .clock (clock),
        .reset (reset),
        .req   (dn_req),
        .rsp   (dn_rsp)
    );

endmodule

// ==== design/apb_delayer.sv ====
`include "apb_delay_defs.svh"

module apb_delayer
    import apb_delay_pkg::*;
#(
    parameter logic [63:0] ratio = 64'(`APB_DELAY_RATIO)
) (
    input  logic     clock,
    input  logic     reset,
    input  apb_req_t up_req,
    output apb_rsp_t up_rsp,
    output apb_req_t dn_req,
    input  apb_rsp_t dn_rsp
);

    if (`APB_DELAY_ON != 0) begin : gen_delay

        delay_state_t state;
        // accumulates ratio per wait cycle, then counts down the extra delay
        logic [63:0]  acc;
        data_t        held_prdata;
        logic         held_pslverr;
        logic         setup_seen;
        logic         release_rsp;

        assign setup_seen  = up_req.psel && !up_req.penable;
        // delay over, response goes out on the next edge
        assign release_rsp = (state == delay) && (acc == '0);

        // address, data and control pass straight through
        // psel and penable are held off while the response is pending,
        // so the bank sees its transfer end as soon as it answers
        always_comb begin
            dn_req = up_req;
            if ((state == delay) || up_rsp.pready) begin
                dn_req.psel    = 1'b0;
                dn_req.penable = 1'b0;
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                state <= idle;
            end else begin
                case (state)
                    idle: begin
                        if (setup_seen) begin
                            state <= active;
                        end
                    end
                    active: begin
                        if (dn_rsp.pready) begin
                            state <= delay;
                        end
                    end
                    delay: begin
                        if (acc == '0) begin
                            state <= idle;
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                acc <= '0;
            end else begin
                case (state)
                    idle: acc <= '0;
                    active: begin
                        if (dn_rsp.pready) begin
                            // integer part is the extra delay D
                            acc <= acc >> `APB_DELAY_FRAC;
                        end else begin
                            acc <= acc + ratio;
                        end
                    end
                    delay: begin
                        if (acc != '0) begin
                            acc <= acc - 64'd1;
                        end
                    end
                    default: acc <= '0;
                endcase
            end
        end

        // bank response captured when the bank completes
        always_ff @(posedge clock) begin
            if ((state == active) && dn_rsp.pready) begin
                held_prdata  <= dn_rsp.prdata;
                held_pslverr <= dn_rsp.pslverr;
            end
        end

        // one-cycle registered response, zero otherwise
        always_ff @(posedge clock) begin
            if (reset) begin
                up_rsp <= '0;
            end else if (release_rsp) begin
                up_rsp.pready  <= 1'b1;
                up_rsp.prdata  <= held_prdata;
                up_rsp.pslverr <= held_pslverr;
            end else begin
                up_rsp <= '0;
            end
        end

    end else begin : gen_bypass

        assign dn_req = up_req;
        assign up_rsp = dn_rsp;

    end

endmodule

// ==== design/apb_reg_bank.sv ====
`include "apb_delay_defs.svh"

module apb_reg_bank
    import apb_delay_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  apb_req_t req,
    output apb_rsp_t rsp
);

    localparam int idx_w = $clog2(`REG_BANK_WORDS);
    localparam logic [idx_w-1:0] last_idx = idx_w'(`REG_BANK_WORDS - 1);

    data_t            mem [`REG_BANK_WORDS];
    wait_t            wait_reg;
    wait_t            wait_cnt;
    addr_t            word_addr;
    logic [idx_w-1:0] idx;
    logic             in_range;
    logic             setup;
    logic             access;
    logic             done;

    // word address, low two bits ignored
    assign word_addr = req.paddr >> 2;
    assign idx       = word_addr[idx_w-1:0];
    assign in_range  = word_addr < `REG_BANK_WORDS;

    assign setup  = req.psel && !req.penable;
    assign access = req.psel && req.penable;
    // access phase ends when the wait counter has run out
    assign done   = access && (wait_cnt == '0);

    // wait counter, loaded at setup and counted down in the access phase
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (setup) begin
            wait_cnt <= wait_reg;
        end else if (access && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - wait_t'(1);
        end
    end

    // word array with byte strobes
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < `REG_BANK_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (done && req.pwrite && in_range) begin
            for (int b = 0; b < `APB_DATA_WIDTH / 8; b++) begin
                if (req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

    // last word doubles as the wait-state setting
    // byte 0 holds the value, so strobe 0 has to be set
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_reg <= '0;
        end else if (done && req.pwrite && in_range && (idx == last_idx) && req.pstrb[0]) begin
            wait_reg <= wait_t'(req.pwdata[2:0]);
        end
    end

    // response straight from the counter and the address decode
    always_comb begin
        rsp = '0;
        rsp.pready = done;
        if (done && !in_range) begin
            rsp.pslverr = 1'b1;
        end
        if (done && in_range && !req.pwrite) begin
            rsp.prdata = mem[idx];
        end
    end

endmodule

// ==== tests/apb_delay_checker.sv ====
`include "apb_delay_defs.svh"

module apb_delay_checker
    import apb_delay_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  addr_t paddr,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  data_t pwdata,
    input  strb_t pstrb,
    input  logic  pready,
    input  data_t prdata,
    input  logic  pslverr,
    output int    error_count,
    output int    check_count,
    output int    done_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // reference model of the bank
    data_t model_mem [`REG_BANK_WORDS];
    wait_t model_wait;

    // transfer in flight, captured at its setup edge
    logic  open;
    int    cycle;
    int    start_cycle;
    int    expected_latency;
    addr_t t_addr;
    logic  t_write;
    data_t t_wdata;
    strb_t t_strb;

    initial begin
        error_count = 0;
        check_count = 0;
        done_count  = 0;
    end

    // edges from setup to the edge where pready is seen high: W + floor(W * ratio) + 3
    function automatic int latency_for(input wait_t w);
        int extra;
        extra = (int'(w) * `APB_DELAY_RATIO) >> `APB_DELAY_FRAC;
        return int'(w) + extra + 3;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic close_transfer();
        int unsigned word;
        word = t_addr >> 2;
        compare_value("pready latency", expected_latency, cycle - start_cycle);
        if (word < `REG_BANK_WORDS) begin
            compare_value("pslverr", 0, pslverr);
            if (!t_write) begin
                compare_value("prdata", model_mem[word], prdata);
            end else begin
                for (int b = 0; b < `APB_DATA_WIDTH / 8; b++) begin
                    if (t_strb[b]) begin
                        model_mem[word][8*b +: 8] = t_wdata[8*b +: 8];
                    end
                end
                // last word also sets the wait states
                if ((word == `REG_BANK_WORDS - 1) && t_strb[0]) begin
                    model_wait = wait_t'(t_wdata[2:0]);
                end
            end
        end else begin
            compare_value("pslverr", 1, pslverr);
            compare_value("prdata", 0, prdata);
        end
        done_count++;
        open = 1'b0;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < `REG_BANK_WORDS; w++) begin
                model_mem[w] = '0;
            end
            model_wait = '0;
            open       = 1'b0;
            cycle      = 0;
        end else begin
            cycle++;
            if (pready) begin
                if (open) begin
                    close_transfer();
                end else begin
                    error_count++;
                    $display("pready went high with no transfer open at %0t", $time);
                end
            end else begin
                compare_value("prdata while pready low", 0, prdata);
                compare_value("pslverr while pready low", 0, pslverr);
            end
            if (psel && !penable && !open) begin
                open             = 1'b1;
                start_cycle      = cycle;
                t_addr           = paddr;
                t_write          = pwrite;
                t_wdata          = pwdata;
                t_strb           = pstrb;
                expected_latency = latency_for(model_wait);
            end
        end
    end

endmodule

// ==== tests/tb_apb_delay.sv ====
`include "apb_delay_defs.svh"

module tb_apb_delay
    import apb_delay_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int period_ns     = 100;
    localparam int reset_cycles  = 4;
    localparam int num_transfers = 300;
    // worst case per transfer is 7 waits plus their scaled delay and some slack
    localparam int max_cycles    = 7 + ((7 * `APB_DELAY_RATIO) >> `APB_DELAY_FRAC) + 6;
    localparam int watchdog_cycles = num_transfers * max_cycles + reset_cycles + 10;

    logic        clock;
    logic        reset;
    addr_t       paddr;
    logic        psel;
    logic        penable;
    prot_t       pprot;
    logic        pwrite;
    data_t       pwdata;
    strb_t       pstrb;
    logic        pready;
    data_t       prdata;
    logic        pslverr;
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          done_count;

    apb_delay_top apb_delay_top_inst (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    apb_delay_checker apb_delay_checker_inst (
        .clock       (clock),
        .reset       (reset),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .error_count (error_count),
        .check_count (check_count),
        .done_count  (done_count)
    );

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // one apb transfer with all changes on the falling edge
    task automatic run_transfer(input addr_t addr, input logic write, input data_t wdata,
                                input strb_t strb, input prot_t prot);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        pstrb   = strb;
        pprot   = prot;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clock);
        penable = 1'b1;
        @(negedge clock);
        while (!pready) begin
            @(negedge clock);
        end
        // transfer completes at the rising edge in between
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] bits;
        addr_t       addr;
        data_t       wdata;
        strb_t       strb;
        logic        write;
        lfsr_state = 32'h74b28cf7;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pprot   = '0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        // reset spans four rising edges and drops on a falling edge
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // a few idle cycles after reset with pready low
        repeat (3) @(negedge clock);
        for (int n = 0; n < num_transfers; n++) begin
            draw_bits(3, pick);
            if (pick == 0) begin
                // new wait value through the last word
                addr  = addr_t'((`REG_BANK_WORDS - 1) * 4);
                write = 1'b1;
                draw_bits(32, wdata);
                draw_bits(4, bits);
                strb  = strb_t'(bits) | strb_t'(1);
            end else begin
                draw_bits(1, bits);
                write = bits[0];
                draw_bits(3, bits);
                if (bits == 0) begin
                    draw_bits(10, bits);
                    addr = 32'h40 + (bits << 2);
                end else begin
                    draw_bits(4, bits);
                    addr = bits << 2;
                end
                draw_bits(32, wdata);
                draw_bits(4, bits);
                strb = strb_t'(bits);
            end
            draw_bits(3, bits);
            run_transfer(addr, write, wdata, strb, prot_t'(bits));
            draw_bits(1, bits);
            if (bits[0]) begin
                @(negedge clock);
            end
        end
        repeat (4) @(negedge clock);
        $display("transfers %0d, checks %0d, errors %0d", done_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * period_ns);
        $display("timeout, the transfers did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule
